// ==== logic/png_filter_pkg.sv ====
//----------------------------------------------------------------------
// png filter shared types: pixel layout, filter types, FSM states
//----------------------------------------------------------------------
package png_filter_pkg;

  // pixel layout, channel k sits in byte k
  localparam int chn_wd = 8;
  localparam int num_chn = 4;
  localparam int pxl_wd = chn_wd * num_chn;

  typedef logic [pxl_wd-1:0] pixel_t;

  // png filter type encoding
  typedef enum logic [2:0] {
    filt_none  = 3'd0,
    filt_sub   = 3'd1,
    filt_up    = 3'd2,
    filt_avg   = 3'd3,
    filt_paeth = 3'd4
  } filter_type_e;

  localparam int num_filt = 5;

  // read strobe to registered filtered write
  localparam int pipe_depth = 3;

  // row phases
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_measure = 2'd1,
    st_select  = 2'd2,
    st_apply   = 2'd3
  } ctrl_state_e;

  // filter type position in the row header word
  localparam int type_lsb = 24;

endpackage

// ==== logic/pixel_window_if.sv ====
//----------------------------------------------------------------------
// pixel neighborhood and residual bundles between the filter stages
//----------------------------------------------------------------------
`timescale 1ns/1ps

// x with left (a), up (b) and up-left (c) neighbors
interface pixel_window_if
  import png_filter_pkg::*;
();
  logic   valid;
  logic   measure;
  logic   first_col;
  pixel_t x;
  pixel_t a;
  pixel_t b;
  pixel_t c;

  modport src (output valid, measure, first_col, x, a, b, c);
  modport dst (input valid, measure, first_col, x, a, b, c);
endinterface

// one residual per filter type, indexed by filter_type_e
interface residual_if
  import png_filter_pkg::*;
();
  logic   valid;
  logic   measure;
  logic   first_col;
  pixel_t res [num_filt];

  modport src (output valid, measure, first_col, res);
  modport dst (input valid, measure, first_col, res);
endinterface

// ==== logic/paeth_predictor.sv ====
//----------------------------------------------------------------------
// paeth predictor for one channel
//----------------------------------------------------------------------
`timescale 1ns/1ps

module paeth_predictor
  import png_filter_pkg::*;
(
  input  logic [chn_wd-1:0] a_i,
  input  logic [chn_wd-1:0] b_i,
  input  logic [chn_wd-1:0] c_i,
  output logic [chn_wd-1:0] pred_o
);

  // distances of p = a + b - c to a, b and c
  logic signed [chn_wd+1:0] pa;
  logic signed [chn_wd+1:0] pb;
  logic signed [chn_wd+1:0] pc;
  logic        [chn_wd+1:0] da;
  logic        [chn_wd+1:0] db;
  logic        [chn_wd+1:0] dc;

  assign pa = $signed({2'b00, b_i}) - $signed({2'b00, c_i});
  assign pb = $signed({2'b00, a_i}) - $signed({2'b00, c_i});
  assign pc = $signed({2'b00, a_i}) + $signed({2'b00, b_i}) - $signed({1'b0, c_i, 1'b0});

  assign da = pa[chn_wd+1] ? -pa : pa;
  assign db = pb[chn_wd+1] ? -pb : pb;
  assign dc = pc[chn_wd+1] ? -pc : pc;

  // ties go to a first, then b
  always_comb begin
    if (da <= db && da <= dc) begin
      pred_o = a_i;
    end else if (db <= dc) begin
      pred_o = b_i;
    end else begin
      pred_o = c_i;
    end
  end

endmodule

// ==== logic/png_filter_ctrl.sv ====
//----------------------------------------------------------------------
// png filter control: row phase FSM, counters, FIFO read strobes
//----------------------------------------------------------------------
`timescale 1ns/1ps

module png_filter_ctrl
  import png_filter_pkg::*;
#(
  parameter int W_WD = 12,
  parameter int H_WD = 12
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic [W_WD-1:0] cfg_w_i,
  input  logic [H_WD-1:0] cfg_h_i,
  input  logic            start_i,
  input  logic            val_i,
  input  logic            select_done_i,
  output logic            select_start_o,
  output logic            x_strobe_o,
  output logic            measure_o,
  output logic            first_col_o,
  output logic            first_row_o,
  output logic            fifo_pre_rd_val_o,
  output logic            fifo_cur_rd_val_o,
  output logic            done_o,
  output logic [H_WD-1:0] cnt_h_o
);

  localparam int DRAIN_WD = $clog2(pipe_depth + 1);

  ctrl_state_e         state_q;
  ctrl_state_e         state_d;
  logic [W_WD-1:0]     cnt_w_q;
  logic [H_WD-1:0]     cnt_h_q;
  logic [DRAIN_WD-1:0] drain_q;
  logic                tail_q;
  logic                last_col;
  logic                drain_end;

  assign last_col  = cnt_w_q == cfg_w_i - 1'b1;
  // tail is set after the last strobe of a phase, pipeline empty at drain_end
  assign drain_end = tail_q && (drain_q == DRAIN_WD'(pipe_depth));

  // one strobe per accepted pixel in measure, back to back in apply
  assign x_strobe_o = !tail_q &&
                      ((state_q == st_measure && val_i) || state_q == st_apply);
  assign measure_o   = state_q == st_measure;
  assign first_col_o = cnt_w_q == '0;
  assign first_row_o = cnt_h_q == '0;

  assign fifo_cur_rd_val_o = x_strobe_o && (state_q == st_apply);
  // no previous row exists on row 0
  assign fifo_pre_rd_val_o = x_strobe_o && !first_row_o;

  assign select_start_o = (state_q == st_measure) && drain_end;
  assign done_o         = (state_q == st_apply) && drain_end;
  assign cnt_h_o        = cnt_h_q;

  //--------------------------------------------------------------------
  // phase FSM
  //--------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (start_i) state_d = st_measure;
      end
      st_measure: begin
        if (drain_end) state_d = st_select;
      end
      st_select: begin
        if (select_done_i) state_d = st_apply;
      end
      st_apply: begin
        if (drain_end) state_d = st_idle;
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  //--------------------------------------------------------------------
  // counters
  //--------------------------------------------------------------------
  // column position and drain after the last column
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_w_q <= '0;
      tail_q  <= 1'b0;
      drain_q <= '0;
    end else if (x_strobe_o) begin
      cnt_w_q <= last_col ? '0 : cnt_w_q + 1'b1;
      if (last_col) begin
        tail_q  <= 1'b1;
        drain_q <= DRAIN_WD'(1);
      end
    end else if (drain_end) begin
      tail_q  <= 1'b0;
      drain_q <= '0;
    end else if (tail_q) begin
      drain_q <= drain_q + 1'b1;
    end
  end

  // row index, wraps after the last row of the image
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_h_q <= '0;
    end else if (done_o) begin
      cnt_h_q <= (cnt_h_q == cfg_h_i - 1'b1) ? '0 : cnt_h_q + 1'b1;
    end
  end

endmodule

// ==== logic/pixel_window.sv ====
//----------------------------------------------------------------------
// pixel window: current pixel with a/b/c neighbors and edge zeroing
//----------------------------------------------------------------------
`timescale 1ns/1ps

module pixel_window
  import png_filter_pkg::*;
(
  input  logic   clk,
  input  logic   rstn,
  input  logic   x_strobe_i,
  input  logic   measure_i,
  input  logic   first_col_i,
  input  logic   first_row_i,
  input  pixel_t dat_i,
  input  pixel_t fifo_cur_rd_dat_i,
  input  pixel_t fifo_pre_rd_dat_i,
  output logic   fifo_cur_wr_val_o,
  output pixel_t fifo_cur_wr_dat_o,
  pixel_window_if.src win
);

  // strobe and tags lined up with the one cycle FIFO read latency
  logic   val_q;
  logic   meas_q;
  logic   fcol_q;
  logic   frow_q;
  pixel_t dat_q;
  pixel_t a_q;
  pixel_t c_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      val_q  <= 1'b0;
      meas_q <= 1'b0;
      fcol_q <= 1'b0;
      frow_q <= 1'b0;
    end else begin
      val_q  <= x_strobe_i;
      meas_q <= measure_i;
      fcol_q <= first_col_i;
      frow_q <= first_row_i;
    end
  end

  always_ff @(posedge clk) begin
    dat_q <= dat_i;
  end

  // measure pixels go straight on to the current-row FIFO
  assign fifo_cur_wr_val_o = val_q && meas_q;
  assign fifo_cur_wr_dat_o = dat_q;

  // x from the input in measure, re-read from the FIFO in apply
  assign win.x = meas_q ? dat_q : fifo_cur_rd_dat_i;
  assign win.b = frow_q ? '0 : fifo_pre_rd_dat_i;
  assign win.a = fcol_q ? '0 : a_q;
  assign win.c = (fcol_q || frow_q) ? '0 : c_q;

  assign win.valid     = val_q;
  assign win.measure   = meas_q;
  assign win.first_col = fcol_q;

  // last x becomes a, last b becomes c
  always_ff @(posedge clk) begin
    if (val_q) begin
      a_q <= win.x;
      c_q <= win.b;
    end
  end

endmodule

// ==== logic/filter_predictor.sv ====
//----------------------------------------------------------------------
// filter predictor: residuals of all five png filter types per channel
//----------------------------------------------------------------------
`timescale 1ns/1ps

module filter_predictor
  import png_filter_pkg::*;
(
  input logic clk,
  input logic rstn,
  pixel_window_if.dst win,
  residual_if.src     res
);

  wire pixel_t res_d [num_filt];

  genvar k;
  for (k = 0; k < num_chn; k++) begin : g_chn
    logic [chn_wd-1:0] x;
    logic [chn_wd-1:0] a;
    logic [chn_wd-1:0] b;
    logic [chn_wd-1:0] c;
    logic [chn_wd-1:0] pred;
    // 9 bit sum keeps the carry for the average
    logic [chn_wd:0]   ab_sum;

    assign x = win.x[k*chn_wd +: chn_wd];
    assign a = win.a[k*chn_wd +: chn_wd];
    assign b = win.b[k*chn_wd +: chn_wd];
    assign c = win.c[k*chn_wd +: chn_wd];
    assign ab_sum = a + b;

    paeth_predictor u_paeth (
      .a_i    (a),
      .b_i    (b),
      .c_i    (c),
      .pred_o (pred)
    );

    // all differences wrap modulo 256
    assign res_d[filt_none][k*chn_wd +: chn_wd]  = x;
    assign res_d[filt_sub][k*chn_wd +: chn_wd]   = x - a;
    assign res_d[filt_up][k*chn_wd +: chn_wd]    = x - b;
    assign res_d[filt_avg][k*chn_wd +: chn_wd]   = x - ab_sum[chn_wd:1];
    assign res_d[filt_paeth][k*chn_wd +: chn_wd] = x - pred;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      res.valid     <= 1'b0;
      res.measure   <= 1'b0;
      res.first_col <= 1'b0;
    end else begin
      res.valid     <= win.valid;
      res.measure   <= win.measure;
      res.first_col <= win.first_col;
    end
  end

  always_ff @(posedge clk) begin
    if (win.valid) begin
      for (int i = 0; i < num_filt; i++) begin
        res.res[i] <= res_d[i];
      end
    end
  end

endmodule

// ==== logic/filter_cost_acc.sv ====
//----------------------------------------------------------------------
// filter cost accumulation over one row for every filter type
//----------------------------------------------------------------------
`timescale 1ns/1ps

module filter_cost_acc
  import png_filter_pkg::*;
#(
  parameter int COST_WD = 22
) (
  input  logic               clk,
  input  logic               rstn,
  residual_if.dst            res,
  output logic [COST_WD-1:0] cost_o [num_filt]
);

  genvar t;
  for (t = 0; t < num_filt; t++) begin : g_type
    // four channel costs, at most 4 x 255
    logic [chn_wd+1:0] pix_cost;

    always_comb begin
      logic [chn_wd-1:0] r;
      pix_cost = '0;
      for (int k = 0; k < num_chn; k++) begin
        r = res.res[t][k*chn_wd +: chn_wd];
        // signed magnitude for the predicting types
        if (t != filt_none && r[chn_wd-1]) begin
          r = {chn_wd{1'b1}} - r;
        end
        pix_cost = pix_cost + r;
      end
    end

    // sum restarts on column 0 of each row
    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        cost_o[t] <= '0;
      end else if (res.valid && res.measure) begin
        cost_o[t] <= (res.first_col ? '0 : cost_o[t]) + COST_WD'(pix_cost);
      end
    end
  end

endmodule

// ==== logic/filter_select.sv ====
//----------------------------------------------------------------------
// filter select: cheapest type search, header and filtered writes
//----------------------------------------------------------------------
`timescale 1ns/1ps

module filter_select
  import png_filter_pkg::*;
#(
  parameter int COST_WD = 22
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               select_start_i,
  input  logic [COST_WD-1:0] cost_i [num_filt],
  residual_if.dst            res,
  output logic               select_done_o,
  output logic               fifo_flt_wr_val_o,
  output pixel_t             fifo_flt_wr_dat_o
);

  // step 0 comes with select_start, steps 0..3 compare, step 4 writes
  logic [2:0]   step_q;
  filter_type_e best_q;
  filter_type_e cand;
  filter_type_e base;
  logic         cmp_en;
  logic         hdr_wr;
  logic         flt_wr;

  assign cand   = filter_type_e'(step_q + 3'd1);
  assign base   = select_start_i ? filt_none : best_q;
  assign cmp_en = select_start_i || (step_q inside {[3'd1:3'd3]});
  assign hdr_wr = step_q == 3'd4;
  assign flt_wr = res.valid && !res.measure;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      step_q            <= '0;
      best_q            <= filt_none;
      select_done_o     <= 1'b0;
      fifo_flt_wr_val_o <= 1'b0;
    end else begin
      if (select_start_i) begin
        step_q <= 3'd1;
      end else if (hdr_wr) begin
        step_q <= '0;
      end else if (step_q != '0) begin
        step_q <= step_q + 3'd1;
      end
      // strictly lower wins, so ties keep the lower type
      if (cmp_en) begin
        best_q <= (cost_i[cand] < cost_i[base]) ? cand : base;
      end
      select_done_o     <= hdr_wr;
      fifo_flt_wr_val_o <= hdr_wr || flt_wr;
    end
  end

  //--------------------------------------------------------------------
  // output word
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (hdr_wr) begin
      fifo_flt_wr_dat_o <= pixel_t'(best_q) << type_lsb;
    end else if (flt_wr) begin
      fifo_flt_wr_dat_o <= res.res[best_q];
    end
  end

endmodule

// ==== logic/png_filter_top.sv ====
//----------------------------------------------------------------------
// png scanline filter top: measure, select and apply per image row
//----------------------------------------------------------------------
`timescale 1ns/1ps

module png_filter_top
  import png_filter_pkg::*;
#(
  parameter int W_WD = 12,
  parameter int H_WD = 12
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic [W_WD-1:0] cfg_w_i,
  input  logic [H_WD-1:0] cfg_h_i,
  input  logic            start_i,
  output logic            done_o,
  output logic [H_WD-1:0] cnt_h_o,
  input  logic            val_i,
  input  pixel_t          dat_i,
  output logic            fifo_cur_wr_val_o,
  output pixel_t          fifo_cur_wr_dat_o,
  output logic            fifo_cur_rd_val_o,
  input  pixel_t          fifo_cur_rd_dat_i,
  output logic            fifo_flt_wr_val_o,
  output pixel_t          fifo_flt_wr_dat_o,
  output logic            fifo_pre_rd_val_o,
  input  pixel_t          fifo_pre_rd_dat_i
);

  // room for a full row of worst case pixel costs
  localparam int COST_WD = chn_wd + 2 + W_WD;

  logic               x_strobe;
  logic               measure;
  logic               first_col;
  logic               first_row;
  logic               select_start;
  logic               select_done;
  logic [COST_WD-1:0] cost [num_filt];

  pixel_window_if win_if ();
  residual_if     res_if ();

  png_filter_ctrl #(
    .W_WD (W_WD),
    .H_WD (H_WD)
  ) u_ctrl (
    .clk               (clk),
    .rstn              (rstn),
    .cfg_w_i           (cfg_w_i),
    .cfg_h_i           (cfg_h_i),
    .start_i           (start_i),
    .val_i             (val_i),
    .select_done_i     (select_done),
    .select_start_o    (select_start),
    .x_strobe_o        (x_strobe),
    .measure_o         (measure),
    .first_col_o       (first_col),
    .first_row_o       (first_row),
    .fifo_pre_rd_val_o (fifo_pre_rd_val_o),
    .fifo_cur_rd_val_o (fifo_cur_rd_val_o),
    .done_o            (done_o),
    .cnt_h_o           (cnt_h_o)
  );

  pixel_window u_window (
    .clk               (clk),
    .rstn              (rstn),
    .x_strobe_i        (x_strobe),
    .measure_i         (measure),
    .first_col_i       (first_col),
    .first_row_i       (first_row),
    .dat_i             (dat_i),
    .fifo_cur_rd_dat_i (fifo_cur_rd_dat_i),
    .fifo_pre_rd_dat_i (fifo_pre_rd_dat_i),
    .fifo_cur_wr_val_o (fifo_cur_wr_val_o),
    .fifo_cur_wr_dat_o (fifo_cur_wr_dat_o),
    .win               (win_if)
  );

  filter_predictor u_predictor (
    .clk  (clk),
    .rstn (rstn),
    .win  (win_if),
    .res  (res_if)
  );

  filter_cost_acc #(
    .COST_WD (COST_WD)
  ) u_cost_acc (
    .clk    (clk),
    .rstn   (rstn),
    .res    (res_if),
    .cost_o (cost)
  );

  filter_select #(
    .COST_WD (COST_WD)
  ) u_select (
    .clk               (clk),
    .rstn              (rstn),
    .select_start_i    (select_start),
    .cost_i            (cost),
    .res               (res_if),
    .select_done_o     (select_done),
    .fifo_flt_wr_val_o (fifo_flt_wr_val_o),
    .fifo_flt_wr_dat_o (fifo_flt_wr_dat_o)
  );

endmodule

// ==== verification/png_filter_tb.sv ====
//----------------------------------------------------------------------
// png filter testbench: FIFO models, reference model and row checks
//----------------------------------------------------------------------
`timescale 1ns/1ps

module png_filter_tb
  import png_filter_pkg::*;
();

  localparam int W_WD = 12;
  localparam int H_WD = 12;
  localparam int max_w = 16;
  localparam int max_h = 4;
  localparam int max_tests = 8;
  localparam logic [31:0] lcg_seed = 32'hed2d_a8f0;

  // pattern kinds
  localparam int pat_const = 0;
  localparam int pat_ramp = 1;
  localparam int pat_rand = 2;

  logic            clk;
  logic            rstn;
  logic [W_WD-1:0] cfg_w;
  logic [H_WD-1:0] cfg_h;
  logic            start;
  logic            done;
  logic [H_WD-1:0] cnt_h;
  logic            val;
  pixel_t          dat;
  logic            cur_wr_val;
  pixel_t          cur_wr_dat;
  logic            cur_rd_val;
  pixel_t          cur_rd_dat;
  logic            flt_wr_val;
  pixel_t          flt_wr_dat;
  logic            pre_rd_val;
  pixel_t          pre_rd_dat;

  // image table
  int         num_tests;
  int         tab_w [max_tests];
  int         tab_h [max_tests];
  int         tab_kind [max_tests];
  int         tab_base [max_tests];
  int         tab_dc [max_tests];
  int         tab_dr [max_tests];
  logic [7:0] tab_gap [max_tests];

  // current image and expected row results
  pixel_t              img [max_h][max_w];
  pixel_t              exp_flt [max_w];
  pixel_t              exp_hdr;
  int                  img_w;
  int                  cur_row;
  logic [num_filt-1:0] type_won;

  // FIFO models and bookkeeping
  pixel_t cur_q [$];
  pixel_t row_store [max_w];
  pixel_t prev_row [max_w];
  int     cur_wr_idx;
  int     pre_idx;
  int     flt_cnt;
  int     rows_done;
  int     errors;
  int     checks;

  png_filter_top #(
    .W_WD (W_WD),
    .H_WD (H_WD)
  ) dut0 (
    .clk               (clk),
    .rstn              (rstn),
    .cfg_w_i           (cfg_w),
    .cfg_h_i           (cfg_h),
    .start_i           (start),
    .done_o            (done),
    .cnt_h_o           (cnt_h),
    .val_i             (val),
    .dat_i             (dat),
    .fifo_cur_wr_val_o (cur_wr_val),
    .fifo_cur_wr_dat_o (cur_wr_dat),
    .fifo_cur_rd_val_o (cur_rd_val),
    .fifo_cur_rd_dat_i (cur_rd_dat),
    .fifo_flt_wr_val_o (flt_wr_val),
    .fifo_flt_wr_dat_o (flt_wr_dat),
    .fifo_pre_rd_val_o (pre_rd_val),
    .fifo_pre_rd_dat_i (pre_rd_dat)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //--------------------------------------------------------------------
  // helpers and reference model
  //--------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic value_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic protocol_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic add_test(input int w, input int h, input int kind, input int base,
                          input int dc, input int dr, input logic [7:0] gap);
    tab_w[num_tests]    = w;
    tab_h[num_tests]    = h;
    tab_kind[num_tests] = kind;
    tab_base[num_tests] = base;
    tab_dc[num_tests]   = dc;
    tab_dr[num_tests]   = dr;
    tab_gap[num_tests]  = gap;
    num_tests++;
  endtask

  // nearest of a, b, c to a + b - c, ties to a then b
  function automatic int paeth_ref(input int a, input int b, input int c);
    int p;
    int pa;
    int pb;
    int pc;
    p  = a + b - c;
    pa = (p > a) ? p - a : a - p;
    pb = (p > b) ? p - b : b - p;
    pc = (p > c) ? p - c : c - p;
    if (pa <= pb && pa <= pc) begin
      return a;
    end else if (pb <= pc) begin
      return b;
    end
    return c;
  endfunction

  function automatic pixel_t residual(input int t, input pixel_t x, input pixel_t a,
                                      input pixel_t b, input pixel_t c);
    pixel_t r;
    int     xk;
    int     ak;
    int     bk;
    int     ck;
    int     pred;
    for (int k = 0; k < num_chn; k++) begin
      xk = int'(x[k*chn_wd +: chn_wd]);
      ak = int'(a[k*chn_wd +: chn_wd]);
      bk = int'(b[k*chn_wd +: chn_wd]);
      ck = int'(c[k*chn_wd +: chn_wd]);
      case (t)
        0: pred = 0;
        1: pred = ak;
        2: pred = bk;
        3: pred = (ak + bk) / 2;
        default: pred = paeth_ref(ak, bk, ck);
      endcase
      r[k*chn_wd +: chn_wd] = 8'(xk - pred);
    end
    return r;
  endfunction

  // raw bytes for none, distance from zero for the rest
  function automatic int pixel_cost(input int t, input pixel_t r);
    int sum;
    int v;
    sum = 0;
    for (int k = 0; k < num_chn; k++) begin
      v = int'(r[k*chn_wd +: chn_wd]);
      if (t != 0 && v >= 128) begin
        v = 255 - v;
      end
      sum += v;
    end
    return sum;
  endfunction

  task automatic build_expected(input int r);
    pixel_t res [num_filt][max_w];
    int     cost [num_filt];
    pixel_t a;
    pixel_t b;
    pixel_t c;
    int     best;
    for (int t = 0; t < num_filt; t++) begin
      cost[t] = 0;
    end
    for (int col = 0; col < img_w; col++) begin
      a = '0;
      b = '0;
      c = '0;
      if (col != 0) begin
        a = img[r][col-1];
      end
      if (r != 0) begin
        b = img[r-1][col];
      end
      if (col != 0 && r != 0) begin
        c = img[r-1][col-1];
      end
      for (int t = 0; t < num_filt; t++) begin
        res[t][col] = residual(t, img[r][col], a, b, c);
        cost[t] += pixel_cost(t, res[t][col]);
      end
    end
    // lowest cost, ties keep the lower type
    best = 0;
    for (int t = 1; t < num_filt; t++) begin
      if (cost[t] < cost[best]) begin
        best = t;
      end
    end
    type_won[best] = 1'b1;
    exp_hdr = '0;
    exp_hdr[type_lsb +: 3] = 3'(best);
    for (int col = 0; col < img_w; col++) begin
      exp_flt[col] = res[best][col];
    end
  endtask

  task automatic gen_image(input int i);
    logic [31:0] s;
    logic [7:0]  v;
    s = lcg_seed ^ 32'(tab_base[i]);
    for (int r = 0; r < tab_h[i]; r++) begin
      for (int c = 0; c < tab_w[i]; c++) begin
        case (tab_kind[i])
          pat_const: begin
            img[r][c] = {num_chn{8'(tab_base[i])}};
          end
          pat_ramp: begin
            v = 8'(tab_base[i] + c * tab_dc[i] + r * tab_dr[i]);
            img[r][c] = {num_chn{v}};
          end
          default: begin
            s = lcg_next(s);
            img[r][c] = s;
          end
        endcase
      end
    end
  endtask

  // one row: start pulse, pixels with gaps, then wait for done
  task automatic run_row(input int i, input int r);
    int c;
    int g;
    int target;
    cur_row = r;
    build_expected(r);
    target = rows_done + 1;
    c = 0;
    g = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (c < img_w) begin
      @(posedge clk);
      if (tab_gap[i][g % 8]) begin
        val <= 1'b0;
      end else begin
        val <= 1'b1;
        dat <= img[r][c];
        c++;
      end
      g++;
    end
    @(posedge clk);
    val <= 1'b0;
    wait (rows_done == target);
  endtask

  //--------------------------------------------------------------------
  // FIFO models and output monitor
  //--------------------------------------------------------------------
  always @(posedge clk) begin
    if (rstn) begin
      if (cur_wr_val) begin
        checks++;
        if (cur_wr_idx >= img_w) begin
          protocol_error("more current-row FIFO writes than pixels in the row");
        end else if (cur_wr_dat !== img[cur_row][cur_wr_idx]) begin
          value_mismatch($sformatf("row %0d col %0d stored %h, expected %h", cur_row,
                                   cur_wr_idx, cur_wr_dat, img[cur_row][cur_wr_idx]));
        end
        cur_q.push_back(cur_wr_dat);
        if (cur_wr_idx < max_w) begin
          row_store[cur_wr_idx] = cur_wr_dat;
        end
        cur_wr_idx++;
      end
      // both read FIFOs answer one cycle after the strobe
      if (cur_rd_val) begin
        if (cur_q.size() == 0) begin
          protocol_error("current-row FIFO read while empty");
        end else begin
          cur_rd_dat <= cur_q.pop_front();
        end
      end
      if (pre_rd_val) begin
        if (cur_row == 0) begin
          protocol_error("previous-row FIFO read on row 0");
        end
        pre_rd_dat <= prev_row[pre_idx];
        pre_idx = (pre_idx + 1 == img_w) ? 0 : pre_idx + 1;
      end
      if (flt_wr_val) begin
        checks++;
        if (flt_cnt == 0) begin
          if (flt_wr_dat !== exp_hdr) begin
            value_mismatch($sformatf("row %0d header %h, expected %h", cur_row,
                                     flt_wr_dat, exp_hdr));
          end
        end else if (flt_cnt > img_w) begin
          protocol_error("filtered write beyond the end of the row");
        end else if (flt_wr_dat !== exp_flt[flt_cnt-1]) begin
          value_mismatch($sformatf("row %0d col %0d filtered %h, expected %h", cur_row,
                                   flt_cnt - 1, flt_wr_dat, exp_flt[flt_cnt-1]));
        end
        flt_cnt++;
      end
      if (done) begin
        checks++;
        if (!flt_wr_val) begin
          value_mismatch("done_o high without a filtered write");
        end
        if (flt_cnt != img_w + 1) begin
          value_mismatch($sformatf("row %0d had %0d filtered writes, expected %0d",
                                   cur_row, flt_cnt, img_w + 1));
        end
        if (cnt_h !== H_WD'(cur_row)) begin
          value_mismatch($sformatf("cnt_h_o %0d, expected %0d", cnt_h, cur_row));
        end
        // this row is the previous row of the next one
        prev_row   = row_store;
        cur_wr_idx = 0;
        pre_idx    = 0;
        flt_cnt    = 0;
        rows_done++;
      end
    end
  end

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial begin
    rstn       = 1'b0;
    start      = 1'b0;
    val        = 1'b0;
    dat        = '0;
    cfg_w      = '0;
    cfg_h      = '0;
    cur_rd_dat = '0;
    pre_rd_dat = '0;
    cur_wr_idx = 0;
    pre_idx    = 0;
    flt_cnt    = 0;
    rows_done  = 0;
    errors     = 0;
    checks     = 0;
    cur_row    = 0;
    img_w      = 1;
    type_won   = '0;
    num_tests  = 0;

    // w, h, kind, base or seed, column step, row step, val gap mask
    add_test(5, 2, pat_const, 0, 0, 0, 8'h00);
    add_test(4, 3, pat_const, 8'h40, 0, 0, 8'h00);
    add_test(8, 2, pat_ramp, 16, 16, -16, 8'h00);
    add_test(6, 3, pat_ramp, 64, -8, 8, 8'h00);
    add_test(7, 3, pat_rand, 1, 0, 0, 8'h00);
    add_test(7, 3, pat_rand, 1, 0, 0, 8'b0100_1010);
    add_test(6, 3, pat_ramp, 64, -8, 8, 8'b0011_0001);

    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    if (done || cur_wr_val || cur_rd_val || pre_rd_val || flt_wr_val) begin
      value_mismatch("strobes not low after reset");
    end

    for (int i = 0; i < num_tests; i++) begin
      gen_image(i);
      @(posedge clk);
      img_w = tab_w[i];
      cfg_w <= W_WD'(tab_w[i]);
      cfg_h <= H_WD'(tab_h[i]);
      for (int r = 0; r < tab_h[i]; r++) begin
        run_row(i, r);
      end
    end

    repeat (5) @(posedge clk);
    for (int t = 0; t < num_filt; t++) begin
      if (!type_won[t]) begin
        protocol_error($sformatf("filter type %0d was never the cheapest", t));
      end
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // run limit from the image sizes in the table
  initial begin : watchdog
    int limit;
    #1;
    limit = 200;
    for (int i = 0; i < num_tests; i++) begin
      limit += (2 * tab_w[i] + 20) * tab_h[i];
    end
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, the DUT did not finish all rows", limit);
    $display("test failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/png_filter_pkg.sv
logic/pixel_window_if.sv
logic/paeth_predictor.sv
logic/png_filter_ctrl.sv
logic/pixel_window.sv
logic/filter_predictor.sv
logic/filter_cost_acc.sv
logic/filter_select.sv
logic/png_filter_top.sv
verification/png_filter_tb.sv

// ==== Bender.yml ====
package:
  name: png_filter

sources:
  - files:
      - logic/png_filter_pkg.sv
      - logic/pixel_window_if.sv
      - logic/paeth_predictor.sv
      - logic/png_filter_ctrl.sv
      - logic/pixel_window.sv
      - logic/filter_predictor.sv
      - logic/filter_cost_acc.sv
      - logic/filter_select.sv
      - logic/png_filter_top.sv
  - target: test
    files:
      - verification/png_filter_tb.sv
